// File: source/wb_pkg.sv
//============================================================================
// Write-back core package
// Widths, depths, function codes and the structs shared by the
// issue tracker, inflight queue, execution units and write-back stage
//============================================================================
`default_nettype none

package wb_pkg;

    // Datapath width and unit indices
    localparam int XLEN = 32;
    localparam int NUM_WB_UNITS = 2;
    localparam logic UNIT_ALU = 1'b0;
    localparam logic UNIT_MUL = 1'b1;

    // Tracking resources
    localparam int INFLIGHT_DEPTH = 4;
    localparam int ID_WIDTH = 2;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int MUL_LATENCY = 3;

    // Live tag ceiling, sized to the tracker's counter
    localparam logic [ID_WIDTH:0] MAX_LIVE = (ID_WIDTH + 1)'(INFLIGHT_DEPTH);

    // ALU function codes
    localparam logic [1:0] FN_ADD = 2'd0;
    localparam logic [1:0] FN_SUB = 2'd1;
    localparam logic [1:0] FN_XOR = 2'd2;
    localparam logic [1:0] FN_AND = 2'd3;

    // Multiplier function codes, low or high half of the unsigned product
    localparam logic [1:0] FN_MUL_LO = 2'd0;
    localparam logic [1:0] FN_MUL_HI = 2'd1;

    // One instruction as presented at issue
    typedef struct packed {
        logic unit_id;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [1:0] fn;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
    } issue_req_t;

    // Tracking entry held in the inflight queue
    typedef struct packed {
        logic unit_id;
        logic [ID_WIDTH-1:0] id;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
    } iq_entry_t;

    // Per-unit completion report
    typedef struct packed {
        logic done;
        logic [XLEN-1:0] rd;
    } unit_wb_t;

    // Register file write
    typedef struct packed {
        logic valid_write;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [ID_WIDTH-1:0] id;
        logic [XLEN-1:0] rd_data;
    } rf_wb_t;

endpackage

`default_nettype wire

// File: source/issue_tracker.sv
//============================================================================
// Issue tracker
// Hands out instruction tags, counts live tags and decides issue readiness
//============================================================================
`default_nettype none

module issue_tracker (
    input  logic clk,
    input  logic rst,

    input  logic issue,
    input  wb_pkg::issue_req_t issue_req,
    input  logic [wb_pkg::NUM_WB_UNITS-1:0] unit_busy,
    input  logic instruction_complete,

    output logic issue_ready,
    output logic push,
    output wb_pkg::iq_entry_t push_entry,
    output logic [wb_pkg::NUM_WB_UNITS-1:0] start
);

    logic [wb_pkg::ID_WIDTH-1:0] next_id;
    logic [wb_pkg::ID_WIDTH:0] live_count;
    logic active;
    logic accept;

    // Set one cycle after reset releases, keeps ready low through reset
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // Room for a tag and the target unit can take work
    assign issue_ready = active & (live_count < wb_pkg::MAX_LIVE)
                       & ~unit_busy[issue_req.unit_id];
    assign accept = issue & issue_ready;

    // Tag counter wraps modulo the tag space
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
        end else if (accept) begin
            next_id <= next_id + 1'b1;
        end
    end

    // Live count, up on issue and down on completion
    always_ff @(posedge clk) begin
        if (rst) begin
            live_count <= '0;
        end else begin
            case ({accept, instruction_complete})
                2'b10:   live_count <= live_count + 1'b1;
                2'b01:   live_count <= live_count - 1'b1;
                default: live_count <= live_count;
            endcase
        end
    end

    // Tracking entry for the queue
    assign push = accept;
    assign push_entry = '{unit_id: issue_req.unit_id, id: next_id, rd_addr: issue_req.rd_addr};

    // Steer start to the chosen unit
    assign start[wb_pkg::UNIT_ALU] = accept & (issue_req.unit_id == wb_pkg::UNIT_ALU);
    assign start[wb_pkg::UNIT_MUL] = accept & (issue_req.unit_id == wb_pkg::UNIT_MUL);

endmodule

`default_nettype wire

// File: source/inflight_queue.sv
//============================================================================
// Inflight queue
// Age-ordered tracking entries with per-entry pop and compaction
// Slot 0 mirrors the incoming push, slots above it are registered
//============================================================================
`default_nettype none

module inflight_queue (
    input  logic clk,
    input  logic rst,

    input  logic push,
    input  wb_pkg::iq_entry_t push_entry,
    input  logic [wb_pkg::INFLIGHT_DEPTH:0] pop,

    output logic [wb_pkg::INFLIGHT_DEPTH:0] valid,
    output wb_pkg::iq_entry_t entries [wb_pkg::INFLIGHT_DEPTH:0]
);

    // Registered slots, oldest entry in the highest slot
    logic [wb_pkg::INFLIGHT_DEPTH:1] q_valid;
    wb_pkg::iq_entry_t q_entries [wb_pkg::INFLIGHT_DEPTH:1];

    logic [wb_pkg::INFLIGHT_DEPTH:1] q_valid_next;
    wb_pkg::iq_entry_t q_entries_next [wb_pkg::INFLIGHT_DEPTH:1];

    // Next state: drop popped entries, pack survivors toward the oldest
    // slot, then place an unpopped push right behind them
    always_comb begin
        int wr;
        wr = wb_pkg::INFLIGHT_DEPTH;
        q_valid_next = '0;
        q_entries_next = q_entries;
        for (int i = wb_pkg::INFLIGHT_DEPTH; i >= 1; i--) begin
            if (q_valid[i] && !pop[i]) begin
                q_valid_next[wr] = 1'b1;
                q_entries_next[wr] = q_entries[i];
                wr = wr - 1;
            end
        end
        // Tag count keeps at least one slot free whenever a push arrives
        if (push && !pop[0] && wr >= 1) begin
            q_valid_next[wr] = 1'b1;
            q_entries_next[wr] = push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_valid <= '0;
        end else begin
            q_valid <= q_valid_next;
        end
    end

    // Entry payload only matters while its valid bit is set
    always_ff @(posedge clk) begin
        q_entries <= q_entries_next;
    end

    // Slot 0 is this cycle's push
    assign valid = {q_valid, push};

    always_comb begin
        entries[0] = push_entry;
        for (int i = 1; i <= wb_pkg::INFLIGHT_DEPTH; i++) begin
            entries[i] = q_entries[i];
        end
    end

endmodule

`default_nettype wire

// File: source/exec_units.sv
//============================================================================
// Execution units
// Single-cycle adder/logic unit and a three-stage unsigned multiplier,
// each holding its result until write-back accepts it
//============================================================================
`default_nettype none

module exec_units (
    input  logic clk,
    input  logic rst,

    input  logic [wb_pkg::NUM_WB_UNITS-1:0] start,
    input  wb_pkg::issue_req_t issue_req,
    input  logic [wb_pkg::NUM_WB_UNITS-1:0] accepted,

    output wb_pkg::unit_wb_t unit_wb [wb_pkg::NUM_WB_UNITS-1:0],
    output logic done_on_first_cycle,
    output logic [wb_pkg::NUM_WB_UNITS-1:0] unit_busy
);

    logic [wb_pkg::XLEN-1:0] alu_result;
    logic [wb_pkg::XLEN-1:0] alu_rd;
    logic alu_done;

    // Multiplier stage valids, stage 1 and 2; stage 3 is mul_done
    logic [wb_pkg::MUL_LATENCY-1:1] mul_v;
    logic [wb_pkg::XLEN-1:0] mul_a;
    logic [wb_pkg::XLEN-1:0] mul_b;
    logic mul_hi_s1;
    logic mul_hi_s2;
    logic [2*wb_pkg::XLEN-1:0] mul_prod;
    logic [wb_pkg::XLEN-1:0] mul_rd;
    logic mul_done;

    // ALU function
    always_comb begin
        case (issue_req.fn)
            wb_pkg::FN_ADD: alu_result = issue_req.src_a + issue_req.src_b;
            wb_pkg::FN_SUB: alu_result = issue_req.src_a - issue_req.src_b;
            wb_pkg::FN_XOR: alu_result = issue_req.src_a ^ issue_req.src_b;
            default:        alu_result = issue_req.src_a & issue_req.src_b;
        endcase
    end

    // Result ready in the start cycle itself
    assign done_on_first_cycle = start[wb_pkg::UNIT_ALU];

    // A new start in the accept cycle keeps done high for the new result
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_done <= 1'b0;
        end else if (start[wb_pkg::UNIT_ALU]) begin
            alu_done <= 1'b1;
        end else if (accepted[wb_pkg::UNIT_ALU]) begin
            alu_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start[wb_pkg::UNIT_ALU]) begin
            alu_rd <= alu_result;
        end
    end

    // Multiplier stage valids and hold flag
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_v <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_v <= {mul_v[1], start[wb_pkg::UNIT_MUL]};
            if (mul_v[wb_pkg::MUL_LATENCY-1]) begin
                mul_done <= 1'b1;
            end else if (accepted[wb_pkg::UNIT_MUL]) begin
                mul_done <= 1'b0;
            end
        end
    end

    // Operand capture, 64-bit product, then half select
    always_ff @(posedge clk) begin
        mul_a <= issue_req.src_a;
        mul_b <= issue_req.src_b;
        mul_hi_s1 <= (issue_req.fn == wb_pkg::FN_MUL_HI);
        mul_prod <= (2*wb_pkg::XLEN)'(mul_a) * (2*wb_pkg::XLEN)'(mul_b);
        mul_hi_s2 <= mul_hi_s1;
        if (mul_v[wb_pkg::MUL_LATENCY-1]) begin
            mul_rd <= mul_hi_s2 ? mul_prod[2*wb_pkg::XLEN-1:wb_pkg::XLEN]
                                : mul_prod[wb_pkg::XLEN-1:0];
        end
    end

    assign unit_wb[wb_pkg::UNIT_ALU] = '{done: alu_done, rd: alu_rd};
    assign unit_wb[wb_pkg::UNIT_MUL] = '{done: mul_done, rd: mul_rd};

    // Busy while a result waits or the pipe is working; free in accept cycle
    assign unit_busy[wb_pkg::UNIT_ALU] = alu_done & ~accepted[wb_pkg::UNIT_ALU];
    assign unit_busy[wb_pkg::UNIT_MUL] = (|mul_v) | (mul_done & ~accepted[wb_pkg::UNIT_MUL]);

endmodule

`default_nettype wire

// File: source/write_back.sv
//============================================================================
// Write-back stage
// Picks one finished instruction per cycle, writes its result and
// returns the accept and tag-free pulses
//============================================================================
`default_nettype none

module write_back (
    input  logic clk,
    input  logic rst,

    input  logic inorder,
    input  logic [wb_pkg::INFLIGHT_DEPTH:0] valid,
    input  wb_pkg::iq_entry_t entries [wb_pkg::INFLIGHT_DEPTH:0],
    output logic [wb_pkg::INFLIGHT_DEPTH:0] pop,

    input  wb_pkg::unit_wb_t unit_wb [wb_pkg::NUM_WB_UNITS-1:0],
    input  logic done_on_first_cycle,
    output logic [wb_pkg::NUM_WB_UNITS-1:0] accepted,

    output wb_pkg::rf_wb_t rf_wb,
    output logic instruction_complete,
    output logic [wb_pkg::ID_WIDTH-1:0] complete_id
);

    logic found;
    logic sel_done;
    wb_pkg::iq_entry_t sel_entry;

    logic sel_done_r;
    wb_pkg::iq_entry_t sel_entry_r;

    // Oldest-first scan of the registered slots
    // In-order stops at the first valid entry, done or not
    always_comb begin
        found = 1'b0;
        sel_done = 1'b0;
        sel_entry = entries[0];
        pop = '0;
        for (int i = wb_pkg::INFLIGHT_DEPTH; i >= 1; i--) begin
            if (!found && valid[i]
                    && (inorder || unit_wb[entries[i].unit_id].done)) begin
                found = 1'b1;
                sel_entry = entries[i];
                sel_done = unit_wb[entries[i].unit_id].done;
                pop[i] = sel_done;
            end
        end
        // Nothing older pending, try the ALU op issued this cycle
        if (!found && valid[0] && (entries[0].unit_id == wb_pkg::UNIT_ALU)) begin
            sel_done = done_on_first_cycle;
            pop[0] = done_on_first_cycle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_done_r <= 1'b0;
        end else begin
            sel_done_r <= sel_done;
        end
    end

    always_ff @(posedge clk) begin
        sel_entry_r <= sel_entry;
    end

    // Register write, never to register zero
    assign rf_wb.valid_write = sel_done_r & (|sel_entry_r.rd_addr);
    assign rf_wb.rd_addr = sel_entry_r.rd_addr;
    assign rf_wb.id = sel_entry_r.id;
    assign rf_wb.rd_data = unit_wb[sel_entry_r.unit_id].rd;

    // Tag free
    assign instruction_complete = sel_done_r;
    assign complete_id = sel_entry_r.id;

    // One-hot accept back to the selected unit
    always_comb begin
        accepted = '0;
        accepted[sel_entry_r.unit_id] = sel_done_r;
    end

endmodule

`default_nettype wire

// File: source/reg_file.sv
//============================================================================
// Register file
// 32 words, one write port from write-back, one combinational read port
//============================================================================
`default_nettype none

module reg_file (
    input  logic clk,
    input  wb_pkg::rf_wb_t rf_wb,
    input  logic [wb_pkg::REG_ADDR_WIDTH-1:0] rs_addr,
    output logic [wb_pkg::XLEN-1:0] rs_data
);

    logic [wb_pkg::XLEN-1:0] regs [2**wb_pkg::REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (rf_wb.valid_write) begin
            regs[rf_wb.rd_addr] <= rf_wb.rd_data;
        end
    end

    // Register zero is hardwired
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

endmodule

`default_nettype wire

// File: source/wb_core_top.sv
//============================================================================
// Write-back core top level
// Tracker, inflight queue, execution units, write-back and register file
//============================================================================
`default_nettype none

module wb_core_top (
    input  logic clk,
    input  logic rst,
    input  logic inorder,

    input  logic issue,
    input  wb_pkg::issue_req_t issue_req,
    output logic issue_ready,

    output wb_pkg::rf_wb_t rf_wb,
    output logic instruction_complete,

    input  logic [wb_pkg::REG_ADDR_WIDTH-1:0] rs_addr,
    output logic [wb_pkg::XLEN-1:0] rs_data
);

    // Tracker to queue and units
    logic push;
    wb_pkg::iq_entry_t push_entry;
    logic [wb_pkg::NUM_WB_UNITS-1:0] start;
    logic [wb_pkg::NUM_WB_UNITS-1:0] unit_busy;

    // Queue and write-back
    logic [wb_pkg::INFLIGHT_DEPTH:0] valid;
    wb_pkg::iq_entry_t entries [wb_pkg::INFLIGHT_DEPTH:0];
    logic [wb_pkg::INFLIGHT_DEPTH:0] pop;

    // Units and write-back
    wb_pkg::unit_wb_t unit_wb [wb_pkg::NUM_WB_UNITS-1:0];
    logic done_on_first_cycle;
    logic [wb_pkg::NUM_WB_UNITS-1:0] accepted;

    issue_tracker i_issue_tracker (
        .clk                  (clk),
        .rst                  (rst),
        .issue                (issue),
        .issue_req            (issue_req),
        .unit_busy            (unit_busy),
        .instruction_complete (instruction_complete),
        .issue_ready          (issue_ready),
        .push                 (push),
        .push_entry           (push_entry),
        .start                (start)
    );

    inflight_queue i_inflight_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .valid      (valid),
        .entries    (entries)
    );

    exec_units i_exec_units (
        .clk                 (clk),
        .rst                 (rst),
        .start               (start),
        .issue_req           (issue_req),
        .accepted            (accepted),
        .unit_wb             (unit_wb),
        .done_on_first_cycle (done_on_first_cycle),
        .unit_busy           (unit_busy)
    );

    // Completion tag also travels in rf_wb.id
    write_back i_write_back (
        .clk                  (clk),
        .rst                  (rst),
        .inorder              (inorder),
        .valid                (valid),
        .entries              (entries),
        .pop                  (pop),
        .unit_wb              (unit_wb),
        .done_on_first_cycle  (done_on_first_cycle),
        .accepted             (accepted),
        .rf_wb                (rf_wb),
        .instruction_complete (instruction_complete),
        .complete_id          ()
    );

    reg_file i_reg_file (
        .clk     (clk),
        .rf_wb   (rf_wb),
        .rs_addr (rs_addr),
        .rs_data (rs_data)
    );

endmodule

`default_nettype wire

// File: verification/wb_checker.sv
//============================================================================
// Write-back checker
// Tracks expected results per tag, compares every completion and register
// write of the DUT, and keeps a mirror of the register file for the sweep
//============================================================================
`default_nettype none

module wb_checker (
    input  logic clk,
    input  logic rst,
    input  logic inorder,
    input  logic [2:0] test_id,
    input  logic exp_valid,
    input  logic [wb_pkg::ID_WIDTH-1:0] exp_id,
    input  logic [wb_pkg::REG_ADDR_WIDTH-1:0] exp_rd,
    input  logic [wb_pkg::XLEN-1:0] exp_data,
    input  wb_pkg::rf_wb_t rf_wb,
    input  logic instruction_complete,
    input  logic sweep,
    input  logic [wb_pkg::REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic [wb_pkg::XLEN-1:0] rs_data,
    output int err_count,
    output int completions,
    output int ooo_count,
    output int live
);

    // Per-tag expectations and the issue order of live tags
    logic [3:0] pending;
    logic [wb_pkg::REG_ADDR_WIDTH-1:0] tag_rd [4];
    logic [wb_pkg::XLEN-1:0] tag_data [4];
    logic [wb_pkg::ID_WIDTH-1:0] order [$];

    // Register mirror, only written addresses are compared
    logic [wb_pkg::XLEN-1:0] mirror [32];
    logic [31:0] written;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "alu";
            3'd2:    return "mul";
            3'd3:    return "inorder";
            3'd4:    return "ooo";
            3'd5:    return "zero";
            3'd6:    return "regs";
            default: return "reset";
        endcase
    endfunction

    task automatic value_err(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s %s: expected %h actual %h", test_name(test_id), what, exp, act);
        err_count++;
    endtask

    task automatic note_err(input string msg);
        $display("%s: %s", test_name(test_id), msg);
        err_count++;
    endtask

    // Outputs are registered, so sample in the middle of the cycle
    always @(negedge clk) begin
        logic [wb_pkg::ID_WIDTH-1:0] id;
        int pos;
        if (rst) begin
            pending = '0;
            written = '0;
            order.delete();
        end else begin
            if (rf_wb.valid_write && !instruction_complete) begin
                note_err("register write seen without a completion");
            end
            if (instruction_complete) begin
                id = rf_wb.id;
                completions++;
                if (!pending[id]) begin
                    note_err("completion for a tag that is not in flight");
                end else begin
                    // Overtaking the oldest tag is only legal out of order
                    if (order[0] != id) begin
                        if (inorder) begin
                            value_err("complete_id", 32'(order[0]), 32'(id));
                        end else begin
                            ooo_count++;
                        end
                    end
                    pos = 0;
                    while (order[pos] != id) begin
                        pos++;
                    end
                    order.delete(pos);
                    pending[id] = 1'b0;
                    // Register zero completes with no write
                    if (rf_wb.valid_write != (tag_rd[id] != '0)) begin
                        value_err("valid_write", 32'(tag_rd[id] != '0), 32'(rf_wb.valid_write));
                    end else if (rf_wb.valid_write) begin
                        if (rf_wb.rd_addr != tag_rd[id]) begin
                            value_err("rd_addr", 32'(tag_rd[id]), 32'(rf_wb.rd_addr));
                        end
                        if (rf_wb.rd_data != tag_data[id]) begin
                            value_err("rd_data", tag_data[id], rf_wb.rd_data);
                        end
                        mirror[tag_rd[id]] = tag_data[id];
                        written[tag_rd[id]] = 1'b1;
                    end
                end
            end
            if (exp_valid) begin
                if (pending[exp_id]) begin
                    note_err("tag issued again while still in flight");
                end
                pending[exp_id] = 1'b1;
                tag_rd[exp_id] = exp_rd;
                tag_data[exp_id] = exp_data;
                order.push_back(exp_id);
            end
            // Address zero reads as zero, never-written registers skipped
            if (sweep && (rs_addr == '0 || written[rs_addr])) begin
                if (rs_data != ((rs_addr == '0) ? '0 : mirror[rs_addr])) begin
                    value_err($sformatf("x%0d", rs_addr),
                              (rs_addr == '0) ? '0 : mirror[rs_addr], rs_data);
                end
            end
        end
        live = order.size();
    end

endmodule

`default_nettype wire

// File: verification/wb_tb.sv
//============================================================================
// Write-back core testbench
// Xorshift instruction stream in both completion modes, expected results
// from the function rules, and a final register sweep
//============================================================================
`default_nettype none

module wb_tb;

    logic clk;
    logic rst;
    logic inorder;
    logic issue;
    wb_pkg::issue_req_t issue_req;
    logic issue_ready;
    wb_pkg::rf_wb_t rf_wb;
    logic instruction_complete;
    logic [wb_pkg::REG_ADDR_WIDTH-1:0] rs_addr;
    logic [wb_pkg::XLEN-1:0] rs_data;

    // Expectation stream and phase info for the checker
    logic exp_valid;
    logic [wb_pkg::ID_WIDTH-1:0] exp_id;
    logic [wb_pkg::REG_ADDR_WIDTH-1:0] exp_rd;
    logic [wb_pkg::XLEN-1:0] exp_data;
    logic [2:0] test_id;
    logic sweep;

    int err_count;
    int completions;
    int ooo_count;
    int live;
    int tb_errors;
    logic [31:0] rng;
    logic [wb_pkg::ID_WIDTH-1:0] next_tag;

    // Set by a wait that ran out of cycles
    logic aborted;
    string abort_msg;

    always #20 clk = ~clk;

    wb_core_top i_wb_core_top (
        .clk                  (clk),
        .rst                  (rst),
        .inorder              (inorder),
        .issue                (issue),
        .issue_req            (issue_req),
        .issue_ready          (issue_ready),
        .rf_wb                (rf_wb),
        .instruction_complete (instruction_complete),
        .rs_addr              (rs_addr),
        .rs_data              (rs_data)
    );

    wb_checker i_wb_checker (
        .clk (clk), .rst (rst), .inorder (inorder), .test_id (test_id),
        .exp_valid (exp_valid), .exp_id (exp_id), .exp_rd (exp_rd), .exp_data (exp_data),
        .rf_wb (rf_wb), .instruction_complete (instruction_complete),
        .sweep (sweep), .rs_addr (rs_addr), .rs_data (rs_data),
        .err_count (err_count), .completions (completions),
        .ooo_count (ooo_count), .live (live)
    );

    // A wait that gave up ends the run at the next rising edge
    always @(posedge clk) begin
        if (aborted) begin
            $display("%s", abort_msg);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Reference result: add/sub/xor/and, or one half of the unsigned product
    function automatic logic [31:0] expected_result(input wb_pkg::issue_req_t req);
        logic [63:0] prod;
        prod = {32'd0, req.src_a} * {32'd0, req.src_b};
        if (req.unit_id == wb_pkg::UNIT_MUL) begin
            return (req.fn == wb_pkg::FN_MUL_HI) ? prod[63:32] : prod[31:0];
        end
        case (req.fn)
            wb_pkg::FN_ADD: return req.src_a + req.src_b;
            wb_pkg::FN_SUB: return req.src_a - req.src_b;
            wb_pkg::FN_XOR: return req.src_a ^ req.src_b;
            default:        return req.src_a & req.src_b;
        endcase
    endfunction

    task automatic request_abort(input string msg);
        abort_msg = msg;
        aborted = 1'b1;
    endtask

    // unit_sel 0 ALU, 1 MUL, 2 either
    task automatic make_req(input int unit_sel, input logic zero_rd,
                            output wb_pkg::issue_req_t req);
        rng = xorshift32(rng);
        req.unit_id = (unit_sel == 2) ? rng[31] : unit_sel[0];
        req.fn = (req.unit_id == wb_pkg::UNIT_MUL) ? {1'b0, rng[7]} : rng[9:8];
        req.rd_addr = zero_rd ? '0 : rng[4:0];
        rng = xorshift32(rng);
        req.src_a = rng;
        rng = xorshift32(rng);
        req.src_b = rng;
    endtask

    // Present the request, wait for ready, then pulse issue for one cycle
    task automatic issue_one(input wb_pkg::issue_req_t req);
        int n;
        n = 0;
        issue_req <= req;
        @(negedge clk);
        while (!issue_ready) begin
            if (n == 100) request_abort("timeout waiting for issue_ready");
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        issue <= 1'b1;
        exp_valid <= 1'b1;
        exp_id <= next_tag;
        exp_rd <= req.rd_addr;
        exp_data <= expected_result(req);
        next_tag = next_tag + 1'b1;
        @(negedge clk);
        if (!issue_ready) begin
            $display("issue_ready dropped while issue was pulsed");
            tb_errors++;
        end
        @(posedge clk);
        issue <= 1'b0;
        exp_valid <= 1'b0;
    endtask

    // Checker counts are updated at negedge, read them at posedge
    task automatic drain();
        int n;
        n = 0;
        @(posedge clk);
        while (live != 0) begin
            if (n == 200) request_abort("timeout waiting for inflight instructions to drain");
            n++;
            @(posedge clk);
        end
    endtask

    task automatic run_block(input int count, input int unit_sel, input logic zero_rd);
        wb_pkg::issue_req_t req;
        for (int i = 0; i < count; i++) begin
            make_req(unit_sel, zero_rd, req);
            issue_one(req);
        end
        drain();
    endtask

    task automatic report_test(input string name, input int issued,
                               input int err_base, input int done_base);
        if (completions - done_base != issued) begin
            $display("ERR %s completions: expected %0d actual %0d",
                     name, issued, completions - done_base);
            tb_errors++;
        end
        $display("%s: %0d issued, %0d completed, %0d errors", name, issued,
                 completions - done_base, err_count + tb_errors - err_base);
    endtask

    initial begin
        int err_base;
        int done_base;
        int ooo_base;
        wb_pkg::issue_req_t req;
        clk = 1'b0;
        rst = 1'b1;
        inorder = 1'b1;
        issue = 1'b0;
        issue_req = '0;
        rs_addr = '0;
        exp_valid = 1'b0;
        exp_id = '0;
        exp_rd = '0;
        exp_data = '0;
        test_id = 3'd0;
        sweep = 1'b0;
        tb_errors = 0;
        aborted = 1'b0;
        next_tag = '0;
        rng = 32'h7fc0_1482;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // ALU, multiplier and mixed streams, all in order
        for (int t = 1; t <= 3; t++) begin
            test_id <= 3'(t);
            err_base = err_count + tb_errors;
            done_base = completions;
            run_block(200, (t == 3) ? 2 : t - 1, 1'b0);
            report_test((t == 1) ? "alu" : (t == 2) ? "mul" : "inorder", 200,
                        err_base, done_base);
        end

        // Each ALU issued behind a multiply must overtake it
        test_id <= 3'd4;
        inorder <= 1'b0;
        err_base = err_count + tb_errors;
        done_base = completions;
        ooo_base = ooo_count;
        for (int p = 0; p < 50; p++) begin
            make_req(1, 1'b0, req);
            issue_one(req);
            make_req(0, 1'b0, req);
            issue_one(req);
            drain();
        end
        if (ooo_count - ooo_base != 50) begin
            $display("ERR ooo overtakes: expected %0d actual %0d", 50, ooo_count - ooo_base);
            tb_errors++;
        end
        run_block(100, 2, 1'b0);
        report_test("ooo", 200, err_base, done_base);

        // Destination zero completes without writing
        test_id <= 3'd5;
        inorder <= 1'b1;
        err_base = err_count + tb_errors;
        done_base = completions;
        run_block(40, 2, 1'b1);
        report_test("zero", 40, err_base, done_base);

        // Read every register against the mirror
        test_id <= 3'd6;
        err_base = err_count + tb_errors;
        done_base = completions;
        for (int a = 0; a < 32; a++) begin
            sweep <= 1'b1;
            rs_addr <= 5'(a);
            @(posedge clk);
        end
        sweep <= 1'b0;
        @(posedge clk);
        report_test("regs", 0, err_base, done_base);

        $display("summary: %0d completions, %0d errors", completions, err_count + tb_errors);
        if (err_count + tb_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/wb_pkg.sv
source/issue_tracker.sv
source/inflight_queue.sv
source/exec_units.sv
source/write_back.sv
source/reg_file.sv
source/wb_core_top.sv
verification/wb_checker.sv
verification/wb_tb.sv

// File: run.sh
#!/bin/sh
# Build the write-back core testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module wb_tb -f vlog.f -o wb_sim \
    && ./obj_dir/wb_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
